/* include/psg_defines.svh */
`ifndef PSG_DEFINES_SVH
`define PSG_DEFINES_SVH

// ************************************************************************
// Clock rates.
// ************************************************************************
`define PSG_CLK_IN_HZ     100000000  // System clock.
`define PSG_TICK_HZ       1789000    // PSG tick, classic 1.789 MHz.

// ************************************************************************
// Channel and datapath widths.
// ************************************************************************
`define PSG_NUM_CHANNELS  3          // Tone channels A, B, C.
`define PSG_PERIOD_BITS   12         // Half-period in ticks.
`define PSG_LEVEL_BITS    10         // Unsigned channel amplitude.
`define PSG_MIX_BITS      16         // Signed mixer output.

// ************************************************************************
// Bus map and mixer reset values.
// ************************************************************************
`define PSG_BASE_NIBBLE   4'h0       // addr[7:4] of the PSG block.
`define MIX_BASE_NIBBLE   4'h8       // addr[7:4] of the mixer block.
`define MIX_GAIN_UNITY    8'd64      // Channel gain of x1.
`define MIX_MASTER_UNITY  8'd128     // Master volume of x1.

`endif

/* logic/psg_pkg.sv */
`default_nettype none

`include "psg_defines.svh"

package psg_pkg;

    typedef logic [`PSG_PERIOD_BITS-1:0]       tone_period_t;  // Half-period, in ticks.
    typedef logic [3:0]                        volume_t;       // 4-bit volume code.
    typedef logic [`PSG_LEVEL_BITS-1:0]        chan_level_t;   // Channel amplitude.
    typedef logic [7:0]                        gain_t;         // Unsigned gain.
    typedef logic signed [`PSG_MIX_BITS-1:0]   mix_sample_t;   // Output sample.

    // Exponential DAC curve, about -3 dB per step.
    // Code 0 is silence, code 15 is full scale.
    localparam chan_level_t LEVEL_TABLE [16] = '{
        10'd0,   10'd8,   10'd11,  10'd16,
        10'd23,  10'd32,  10'd45,  10'd64,
        10'd90,  10'd128, 10'd181, 10'd256,
        10'd362, 10'd512, 10'd723, 10'd1023
    };

    // Volume code to linear amplitude.
    function automatic chan_level_t level_of(input volume_t code);
        return LEVEL_TABLE[code];
    endfunction

endpackage

`default_nettype wire

/* logic/fp_clk_divider.sv */
`default_nettype none
`timescale 1ns/100ps

// Fractional divider. A phase accumulator steps by OUTPUT_HZ each clock
// and wraps at INPUT_HZ, so the mean strobe rate is exact to the Hz.
module fp_clk_divider #(
    parameter int unsigned INPUT_HZ  = 100000000,
    parameter int unsigned OUTPUT_HZ = 1789000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // One spare bit so the sum never overflows before the compare.
    localparam int ACC_BITS = $clog2(INPUT_HZ + OUTPUT_HZ) + 1;
    localparam logic [ACC_BITS-1:0] STEP = ACC_BITS'(OUTPUT_HZ);
    localparam logic [ACC_BITS-1:0] WRAP = ACC_BITS'(INPUT_HZ);

    logic [ACC_BITS-1:0] phase_q;
    logic [ACC_BITS-1:0] phase_next;
    logic                wrap;

    assign phase_next = phase_q + STEP;      // Advance by the output rate.
    assign wrap       = (phase_next >= WRAP); // Crossed one input period.

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= '0;
            tick    <= 1'b0;
        end else begin
            // Keep the remainder, that is the fractional part.
            phase_q <= wrap ? (phase_next - WRAP) : phase_next;
            tick    <= wrap;                    // One-cycle strobe.
        end
    end

    // ************************************************************************
    // Checks.
    // ************************************************************************

    // Output rate is below half the input, so strobes never touch.
    a_tick_single : assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    );

endmodule

`default_nettype wire

/* logic/psg_registers.sv */
`default_nettype none
`timescale 1ns/100ps

`include "psg_defines.svh"

module psg_registers (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             addr,
    input  logic [7:0]             data,
    input  logic                   wr_n,
    output psg_pkg::tone_period_t  period [`PSG_NUM_CHANNELS],
    output logic [`PSG_NUM_CHANNELS-1:0] tone_off,
    output psg_pkg::volume_t       volume [`PSG_NUM_CHANNELS],
    output logic [7:0]             rd_data
);

    localparam logic [3:0] MIXER_REG = 4'd7;   // Tone-disable bits.
    localparam logic [3:0] VOL_BASE  = 4'd8;   // Volume A, B, C follow.

    logic [7:0] regs_q [16];   // Byte-wide register file.
    logic       wr_en;

    // Bits the real chip keeps. Everything else reads back 0.
    function automatic logic [7:0] write_mask(input logic [3:0] idx);
        case (idx)
            4'd0, 4'd2, 4'd4: return 8'hFF;    // Period fine.
            4'd1, 4'd3, 4'd5: return 8'h0F;    // Period coarse.
            4'd7:             return 8'h07;    // Tone disable, no noise or IO.
            4'd8, 4'd9, 4'd10: return 8'h0F;   // Volume, no envelope mode.
            default:          return 8'h00;    // Unused or dropped.
        endcase
    endfunction

    assign wr_en = !wr_n && (addr[7:4] == `PSG_BASE_NIBBLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= 8'h00;
            end
        end else if (wr_en) begin
            regs_q[addr[3:0]] <= data & write_mask(addr[3:0]);
        end
    end

    // ************************************************************************
    // Field decode.
    // ************************************************************************
    always_comb begin
        for (int i = 0; i < `PSG_NUM_CHANNELS; i++) begin
            // Coarse nibble on top of the fine byte.
            period[i] = {regs_q[2*i+1][3:0], regs_q[2*i]};
            volume[i] = regs_q[VOL_BASE + 4'(i)][3:0];
        end
    end

    assign tone_off = regs_q[MIXER_REG][`PSG_NUM_CHANNELS-1:0]; // Set bit holds high.
    assign rd_data  = regs_q[addr[3:0]];     // Registered in the top level.

    // Envelope-mode bits are never stored, whatever was written.
    a_vol_masked : assert property (
        @(posedge clk) disable iff (rst)
        ((regs_q[8] | regs_q[9] | regs_q[10]) & 8'hF0) == 8'h00
    );

endmodule

`default_nettype wire

/* logic/tone_channel.sv */
`default_nettype none
`timescale 1ns/100ps

// One square-wave voice. The square state flips every period ticks.
module tone_channel (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  psg_pkg::tone_period_t period,
    input  logic                  tone_off,
    input  psg_pkg::volume_t      volume,
    output psg_pkg::chan_level_t  level,
    output logic                  high
);

    psg_pkg::tone_period_t eff_period;   // Period with 0 read as 1.
    psg_pkg::tone_period_t cnt_q;        // Ticks into the half-period.
    logic                  square_q;     // Raw square state.
    logic                  tick_d;       // Tick, one cycle late.

    assign eff_period = (period == '0) ? psg_pkg::tone_period_t'(1) : period;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q    <= '0;
            square_q <= 1'b0;
            tick_d   <= 1'b0;
            level    <= '0;
            high     <= 1'b0;
        end else begin
            tick_d <= tick;
            if (tick) begin
                // Last tick of the half-period. A shortened period
                // also lands here, so the count never runs past it.
                if (cnt_q >= eff_period - 1'b1) begin
                    cnt_q    <= '0;
                    square_q <= ~square_q;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
            // Output stage sees the state updated on the tick.
            if (tick_d) begin
                level <= psg_pkg::level_of(volume);
                high  <= square_q | tone_off;    // Disabled voice sits high.
            end
        end
    end

    // ************************************************************************
    // Checks.
    // ************************************************************************

    // Count stays inside the period seen on the tick.
    a_cnt_in_range : assert property (
        @(posedge clk) disable iff (rst) tick |=> (cnt_q < $past(eff_period))
    );

endmodule

`default_nettype wire

/* logic/channel_mixer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "psg_defines.svh"

module channel_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tick,
    input  logic [7:0]           addr,
    input  logic [7:0]           data,
    input  logic                 wr_n,
    input  psg_pkg::chan_level_t level [`PSG_NUM_CHANNELS],
    input  logic [`PSG_NUM_CHANNELS-1:0] high,
    output logic [7:0]           rd_data,
    output psg_pkg::mix_sample_t sound
);

    localparam int N = `PSG_NUM_CHANNELS;
    localparam logic [3:0] MASTER_REG = 4'(N);      // Follows the gains.
    localparam logic [3:0] INV_REG    = 4'(N + 1);  // Invert mask.
    localparam logic signed [31:0] SAMPLE_MAX = 32'sd32767;
    localparam logic signed [31:0] SAMPLE_MIN = -32'sd32768;

    psg_pkg::gain_t   gain_q [N];      // Per-channel gain, 64 is x1.
    psg_pkg::gain_t   master_q;        // Master volume, 128 is x1.
    logic [N-1:0]     inv_q;           // Phase inversion per channel.
    logic             wr_en;
    logic             tick_d;          // Channel outputs update here.
    logic             mix_stb;         // Channel outputs are settled.
    logic             clamp_q;         // Last sample was saturated.

    logic signed [31:0] signed_lvl [N];
    logic signed [31:0] term [N];
    logic signed [31:0] sum_w;
    logic signed [31:0] scaled_w;
    logic               clamp_hi;
    logic               clamp_lo;

    assign wr_en = !wr_n && (addr[7:4] == `MIX_BASE_NIBBLE);

    // ************************************************************************
    // Control registers.
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                gain_q[i] <= `MIX_GAIN_UNITY;
            end
            master_q <= `MIX_MASTER_UNITY;
            inv_q    <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < N; i++) begin
                if (addr[3:0] == 4'(i)) gain_q[i] <= data;
            end
            if (addr[3:0] == MASTER_REG) master_q <= data;
            if (addr[3:0] == INV_REG)    inv_q    <= data[N-1:0]; // Upper bits dropped.
        end
    end

    always_comb begin
        rd_data = 8'h00;                    // Unused addresses.
        for (int i = 0; i < N; i++) begin
            if (addr[3:0] == 4'(i)) rd_data = gain_q[i];
        end
        if (addr[3:0] == MASTER_REG) rd_data = master_q;
        if (addr[3:0] == INV_REG)    rd_data = 8'(inv_q);
    end

    // ************************************************************************
    // Datapath. Wide signed math, then one clamp at the end.
    // ************************************************************************
    always_comb begin
        sum_w = '0;
        for (int i = 0; i < N; i++) begin
            // Square wave centred on zero.
            signed_lvl[i] = high[i] ? 32'(level[i]) : -32'(level[i]);
            term[i] = (signed_lvl[i] * $signed({24'd0, gain_q[i]})) >>> 6;
            if (inv_q[i]) term[i] = -term[i];
            sum_w = sum_w + term[i];
        end
        scaled_w = (sum_w * $signed({24'd0, master_q})) >>> 7;
    end

    assign clamp_hi = (scaled_w > SAMPLE_MAX);
    assign clamp_lo = (scaled_w < SAMPLE_MIN);

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_d  <= 1'b0;
            mix_stb <= 1'b0;
            clamp_q <= 1'b0;
            sound   <= '0;
        end else begin
            tick_d  <= tick;
            mix_stb <= tick_d;
            if (mix_stb) begin
                clamp_q <= clamp_hi | clamp_lo;
                if (clamp_hi) sound <= psg_pkg::mix_sample_t'(SAMPLE_MAX);
                else if (clamp_lo) sound <= psg_pkg::mix_sample_t'(SAMPLE_MIN);
                else sound <= scaled_w[`PSG_MIX_BITS-1:0];
            end
        end
    end

    // An overrange sum shows up as a flagged full-scale sample.
    a_clamp_flag : assert property (
        @(posedge clk) disable iff (rst)
        mix_stb && (clamp_hi || clamp_lo) |=>
            clamp_q && ((sound == SAMPLE_MAX[15:0]) || (sound == SAMPLE_MIN[15:0]))
    );

endmodule

`default_nettype wire

/* logic/psg_system.sv */
`default_nettype none
`timescale 1ns/100ps

`include "psg_defines.svh"

// Single PSG with three tone voices and a mono mixer.
module psg_system (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           addr,
    input  logic [7:0]           data,
    input  logic                 wr_n,
    output logic [7:0]           dout,
    output psg_pkg::mix_sample_t sound
);

    logic                                 tick;      // PSG clock enable.
    psg_pkg::tone_period_t                period [`PSG_NUM_CHANNELS];
    logic [`PSG_NUM_CHANNELS-1:0]         tone_off;
    psg_pkg::volume_t                     volume [`PSG_NUM_CHANNELS];
    psg_pkg::chan_level_t                 level  [`PSG_NUM_CHANNELS];
    logic [`PSG_NUM_CHANNELS-1:0]         high;
    logic [7:0]                           psg_rd;    // PSG block read value.
    logic [7:0]                           mix_rd;    // Mixer block read value.

    // ************************************************************************
    // Tick generation.
    // ************************************************************************
    fp_clk_divider #(
        .INPUT_HZ  (`PSG_CLK_IN_HZ),
        .OUTPUT_HZ (`PSG_TICK_HZ)
    ) div_i (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    psg_registers regs_i (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .data     (data),
        .wr_n     (wr_n),
        .period   (period),
        .tone_off (tone_off),
        .volume   (volume),
        .rd_data  (psg_rd)
    );

    // One voice per channel, A first.
    for (genvar ch = 0; ch < `PSG_NUM_CHANNELS; ch++) begin : g_chan
        tone_channel chan_i (
            .clk      (clk),
            .rst      (rst),
            .tick     (tick),
            .period   (period[ch]),
            .tone_off (tone_off[ch]),
            .volume   (volume[ch]),
            .level    (level[ch]),
            .high     (high[ch])
        );
    end

    channel_mixer mix_i (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .addr    (addr),
        .data    (data),
        .wr_n    (wr_n),
        .level   (level),
        .high    (high),
        .rd_data (mix_rd),
        .sound   (sound)
    );

    // Read-back. Block picked by the upper address nibble.
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= 8'h00;
        end else begin
            case (addr[7:4])
                `PSG_BASE_NIBBLE: dout <= psg_rd;
                `MIX_BASE_NIBBLE: dout <= mix_rd;
                default:          dout <= 8'h00;  // Nothing mapped.
            endcase
        end
    end

endmodule

`default_nettype wire

/* test/psg_system_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "psg_defines.svh"

module psg_system_tb;

    localparam int CLK_PERIOD   = 8;                         // ns.
    localparam int N            = `PSG_NUM_CHANNELS;
    localparam int TICK_CYCLES  = (`PSG_CLK_IN_HZ + `PSG_TICK_HZ - 1) / `PSG_TICK_HZ;
    localparam int SETTLE       = 3 * TICK_CYCLES + 4;       // Worst-case delay from a write to sound.
    localparam int RUN_NOMINAL  = 4 * `PSG_CLK_IN_HZ / `PSG_TICK_HZ; // Four ticks.
    localparam int RUN_LIMIT    = 4 * RUN_NOMINAL;           // Sign stuck beyond this.
    // Suite needs a few thousand cycles, so this only trips on a hang.
    localparam int WATCHDOG_CYCLES = 200000;

    logic                 clk;
    logic                 rst;
    logic [7:0]           addr;
    logic [7:0]           data;
    logic                 wr_n;
    logic [7:0]           dout;
    psg_pkg::mix_sample_t sound;

    int seed = 20322;

    // Shadow copy of the registers that the mix model reads.
    psg_pkg::volume_t vol_m  [N];
    psg_pkg::gain_t   gain_m [N];
    psg_pkg::gain_t   master_m;
    logic [N-1:0]     inv_m;

    psg_system dut_i (
        .clk   (clk),
        .rst   (rst),
        .addr  (addr),
        .data  (data),
        .wr_n  (wr_n),
        .dout  (dout),
        .sound (sound)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the testbench did not finish in time.");
        $display("TEST FAILED");
        $fatal(1, "Timeout.");
    end

    // ************************************************************************
    // Checks and reference model.
    // ************************************************************************
    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Byte mismatch.");
        end
    endtask

    task automatic check_sample(input string name, input psg_pkg::mix_sample_t got,
                                input psg_pkg::mix_sample_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Sample mismatch.");
        end
    endtask

    task automatic abort_run(input string why);
        $display("t=%0t %s", $time, why);
        $display("TEST FAILED");
        $fatal(1, "Check failed.");
    endtask

    // Bits kept per PSG register, as on the original chip.
    function automatic logic [7:0] psg_mask(input int idx);
        case (idx)
            0, 2, 4:  return 8'hFF;   // Period fine.
            1, 3, 5:  return 8'h0F;   // Period coarse.
            7:        return 8'h07;   // Tone disable A to C.
            8, 9, 10: return 8'h0F;   // Volume.
            default:  return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] mixer_mask(input int idx);
        if (idx < N + 1) return 8'hFF;   // Gains and master.
        if (idx == N + 1) return 8'h07;  // Invert mask.
        return 8'h00;
    endfunction

    // Expected sound for the given channel states.
    function automatic psg_pkg::mix_sample_t mix_model(input logic [N-1:0] hi);
        int lvl;
        int term;
        int sum;
        int scaled;
        sum = 0;
        for (int i = 0; i < N; i++) begin
            lvl = int'(psg_pkg::level_of(vol_m[i]));
            if (!hi[i]) lvl = -lvl;                    // Low half of the square.
            term = (lvl * int'(gain_m[i])) >>> 6;
            if (inv_m[i]) term = -term;
            sum += term;
        end
        scaled = (sum * int'(master_m)) >>> 7;
        if (scaled > 32767) scaled = 32767;           // Clamp to 16 bits.
        else if (scaled < -32768) scaled = -32768;
        return psg_pkg::mix_sample_t'(scaled);
    endfunction

    // ************************************************************************
    // Bus access and setup.
    // ************************************************************************
    task automatic bus_write(input logic [7:0] wa, input logic [7:0] wd);
        @(negedge clk);
        addr = wa;
        data = wd;
        wr_n = 1'b0;          // One-cycle strobe.
        @(negedge clk);
        wr_n = 1'b1;
    endtask

    task automatic bus_read(input logic [7:0] ra, output logic [7:0] rd);
        @(negedge clk);
        addr = ra;
        wr_n = 1'b1;
        @(negedge clk);
        rd = dout;            // Registered one cycle after addr.
    endtask

    task automatic program_tone(input logic [11:0] per, input logic [2:0] off);
        for (int i = 0; i < N; i++) begin
            bus_write(8'(2 * i), per[7:0]);
            bus_write(8'(2 * i + 1), {4'h0, per[11:8]});
        end
        bus_write(8'h07, {5'd0, off});
    endtask

    task automatic program_mixer(input logic [11:0] vols, input logic [23:0] gains,
                                 input logic [7:0] master, input logic [2:0] inv);
        for (int i = 0; i < N; i++) begin
            vol_m[i]  = vols[4*i +: 4];
            gain_m[i] = gains[8*i +: 8];
            bus_write(8'h08 + 8'(i), {4'h0, vol_m[i]});
            bus_write({`MIX_BASE_NIBBLE, 4'(i)}, gain_m[i]);
        end
        master_m = master;
        inv_m    = inv;
        bus_write({`MIX_BASE_NIBBLE, 4'(N)}, master);
        bus_write({`MIX_BASE_NIBBLE, 4'(N + 1)}, {5'd0, inv});
    endtask

    task automatic wait_settle();
        repeat (SETTLE) @(negedge clk);
    endtask

    // Cycles until the sign of sound flips. Called on a falling edge.
    task automatic measure_run(output int cycles);
        logic start_pos;
        start_pos = (sound > 0);
        cycles = 0;
        while ((sound > 0) == start_pos) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) abort_run("Sound kept one sign far too long.");
        end
    endtask

    // ************************************************************************
    // Tests.
    // ************************************************************************
    task automatic reset_defaults();
        logic [7:0] got;
        logic [7:0] exp [5] = '{8'd64, 8'd64, 8'd64, 8'd128, 8'd0};
        check_sample("sound", sound, '0);
        for (int i = 0; i < 5; i++) begin
            bus_read({`MIX_BASE_NIBBLE, 4'(i)}, got);
            check_byte($sformatf("mix[%0d]", i), got, exp[i]);
        end
    endtask

    task automatic register_readback();
        logic [7:0] val [16];
        logic [7:0] got;
        for (int i = 0; i < 16; i++) begin
            val[i] = 8'($random(seed));
            bus_write({`PSG_BASE_NIBBLE, 4'(i)}, val[i]);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read({`PSG_BASE_NIBBLE, 4'(i)}, got);
            check_byte($sformatf("psg[%0d]", i), got, val[i] & psg_mask(i));
        end
        for (int i = 0; i < 16; i++) begin
            val[i] = 8'($random(seed));
            bus_write({`MIX_BASE_NIBBLE, 4'(i)}, val[i]);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read({`MIX_BASE_NIBBLE, 4'(i)}, got);
            check_byte($sformatf("mix[%0d]", i), got, val[i] & mixer_mask(i));
        end
        // Unmapped blocks swallow writes and read as zero.
        for (int n = 1; n < 16; n++) begin
            if (n != 8) begin
                bus_write({4'(n), 4'($random(seed))}, 8'($random(seed)));
                bus_read({4'(n), 4'($random(seed))}, got);
                check_byte($sformatf("nibble %0d", n), got, 8'h00);
            end
        end
    endtask

    task automatic held_high_mix();
        program_tone(12'd100, 3'b111);                  // All voices held high.
        for (int k = 0; k < 4; k++) begin
            program_mixer(12'($random(seed)), 24'($random(seed)), `MIX_MASTER_UNITY, 3'b000);
            wait_settle();
            check_sample("sound", sound, mix_model(3'b111));
            program_mixer({vol_m[2], vol_m[1], vol_m[0]}, {gain_m[2], gain_m[1], gain_m[0]},
                          `MIX_MASTER_UNITY, 3'($random(seed)) | 3'b001);
            wait_settle();
            check_sample("sound inverted", sound, mix_model(3'b111));
        end
    endtask

    // Three full-scale voices peak at 24360 and stay inside the 16-bit range.
    task automatic loud_mix();
        program_tone(12'd100, 3'b111);
        program_mixer(12'hFFF, 24'hFFFFFF, 8'd255, 3'b000);
        wait_settle();
        check_sample("sound loud", sound, mix_model(3'b111));
        program_mixer(12'hFFF, 24'hFFFFFF, 8'd255, 3'b111);
        wait_settle();
        check_sample("sound loud inverted", sound, mix_model(3'b111));
    endtask

    task automatic tone_toggle();
        int   run;
        logic pos;                                      // Expected state of voice A.
        program_mixer(12'h00F, 24'h404040, `MIX_MASTER_UNITY, 3'b000); // Only A audible.
        program_tone(12'd4, 3'b110);                    // A toggles, B and C held.
        wait_settle();
        measure_run(run);                               // First run is partial.
        pos = (sound > 0);                              // Phase reference.
        for (int k = 0; k < 4; k++) begin
            measure_run(run);
            pos = !pos;                                 // Square flips every run.
            check_sample("sound tone", sound, mix_model({2'b11, pos}));
            if (run < RUN_NOMINAL - TICK_CYCLES || run > RUN_NOMINAL + TICK_CYCLES)
                abort_run($sformatf("Tone half-period of %0d cycles is out of range.", run));
        end
    endtask

    task automatic master_mute();
        program_tone(12'($random(seed)) & 12'h007, 3'($random(seed)));
        program_mixer(12'($random(seed)) | 12'h888, 24'($random(seed)), 8'd0,
                      3'($random(seed)));
        wait_settle();
        repeat (4 * TICK_CYCLES) begin
            @(negedge clk);
            check_sample("sound muted", sound, '0);
        end
    endtask

    // ************************************************************************
    // Main sequence.
    // ************************************************************************
    initial begin
        rst  = 1'b1;
        addr = 8'h00;
        data = 8'h00;
        wr_n = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        reset_defaults();
        register_readback();
        held_high_mix();
        loud_mix();
        tone_toggle();
        master_mute();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
logic/psg_pkg.sv
logic/fp_clk_divider.sv
logic/psg_registers.sv
logic/tone_channel.sv
logic/channel_mixer.sv
logic/psg_system.sv
test/psg_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PSG testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f sim.f --top-module psg_system_tb -o psg_sim \
    || { echo "Verilator build failed."; exit 1; }

./obj_dir/psg_sim > sim.log 2>&1 || true
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure."; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }
exit 0
